//--- all.f
design/qla_pkg.sv
design/reg_decode.sv
design/axis_cmd_regs.sv
design/safety_monitor.sv
design/read_mux.sv
design/qla_ctrl_top.sv
test/tb_qla_ctrl.sv

//--- run.sh
#!/bin/sh
# build and run the controller testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module tb_qla_ctrl -o sim_qla

./obj_dir/sim_qla | tee sim.log

# a run without the pass line counts as a failure
grep -q "Test passed" sim.log
echo "simulation passed"

//--- test/tb_qla_ctrl.sv
// --------------------
// drives qla_ctrl_top on the falling edge, checks it against a cycle model
// model follows the bus timing, two edges per write and one per read
// --------------------
`timescale 1ns/1ps

module tb_qla_ctrl import qla_pkg::*; ();

    localparam sample_t MARGIN     = 16'h0200;
    localparam int      LIMIT      = 4;
    localparam int      RST_CYCLES = 8;
    // run length, four cycles per write, two per read or strobe
    localparam int N_WRITES    = 10;
    localparam int N_READS     = 20;
    localparam int N_STROBES   = 10;
    localparam int TEST_CYCLES = RST_CYCLES + 4*N_WRITES + 2*N_READS + 2*N_STROBES;
    localparam int MAX_CYCLES  = 2*TEST_CYCLES + 20;

    logic sysclk = 1'b0;
    logic rst_n;
    logic reg_wen;
    addr_t reg_waddr;
    data_t reg_wdata;
    addr_t reg_raddr;
    data_t reg_rdata;
    samples_t cur_fb;
    logic cur_ready;
    logic [3:0] board_id;
    samples_t cur_cmd;
    axis_mask_t amp_enable;
    axis_mask_t amp_disable;
    logic pwr_enable;

    // reference model state
    samples_t   m_cmd;
    samples_t   m_fb;
    axis_mask_t m_amp_en;
    axis_mask_t m_amp_dis;
    logic       m_pwr;
    data_t      m_rdata;
    int         m_cnt [NUM_AXES];   // over-current streak per axis
    logic       w_valid;            // write seen on the last edge
    addr_t      w_addr;
    data_t      w_data;

    int      err_count  = 0;
    int      n_checks   = 0;
    int      cycle_cnt  = 0;
    logic    saw_trip   = 1'b0;
    logic    saw_restore = 1'b0;
    sample_t cmd_val [NUM_AXES];
    samples_t fb_vec;

    always #20 sysclk = ~sysclk;   // 40 ns

    qla_ctrl_top #(
        .SAFETY_MARGIN (MARGIN),
        .SAFETY_LIMIT  (LIMIT)
    ) u_dut (
        .sysclk      (sysclk),
        .rst_n       (rst_n),
        .reg_wen     (reg_wen),
        .reg_waddr   (reg_waddr),
        .reg_wdata   (reg_wdata),
        .reg_raddr   (reg_raddr),
        .reg_rdata   (reg_rdata),
        .cur_fb      (cur_fb),
        .cur_ready   (cur_ready),
        .board_id    (board_id),
        .cur_cmd     (cur_cmd),
        .amp_enable  (amp_enable),
        .amp_disable (amp_disable),
        .pwr_enable  (pwr_enable)
    );

    // --------------------
    // reference model
    function automatic int sample_mag(sample_t s);
        int d;
        d = int'(s) - 32768;          // offset binary to signed
        return (d < 0) ? -d : d;
    endfunction

    function automatic data_t expected_read(addr_t a);
        data_t r;
        int    ch;
        r  = '0;
        ch = int'(a[7:4]);
        if (a[15:12] != 4'd0) begin
            return r;                  // dropped blocks
        end
        if (ch == 0 && a[3:0] == 4'd0) begin
            r[3:0]   = m_amp_en;
            r[11:8]  = m_amp_dis;
            r[19]    = m_pwr;
            r[27:24] = board_id;
        end else if (ch >= 1 && ch <= NUM_AXES && a[3:0] == 4'd0) begin
            r[15:0] = m_fb[(ch-1)*16 +: 16];
        end else if (ch >= 1 && ch <= NUM_AXES && a[3:0] == 4'd1) begin
            r[15:0] = m_cmd[(ch-1)*16 +: 16];
        end
        return r;
    endfunction

    always @(posedge sysclk) begin : ref_model
        axis_mask_t clr;
        axis_mask_t en_next;
        logic       brd_wr;
        if (!rst_n) begin
            m_cmd     <= {NUM_AXES{SAMPLE_MID}};
            m_amp_en  <= '0;
            m_amp_dis <= '0;
            m_pwr     <= 1'b0;
            m_rdata   <= '0;
            w_valid   <= 1'b0;
            for (int i = 0; i < NUM_AXES; i++) begin
                m_cnt[i] <= 0;
            end
        end else begin
            w_valid <= reg_wen;        // write lands one edge later
            w_addr  <= reg_waddr;
            w_data  <= reg_wdata;
            brd_wr  = w_valid && (w_addr == 16'h0000);
            clr     = '0;
            if (brd_wr && w_data[21]) clr = w_data[3:0];
            if (brd_wr && w_data[20] && w_data[19]) clr = '1;   // power-on re-enables all
            en_next = (brd_wr && w_data[21]) ? w_data[3:0] : m_amp_en;
            m_amp_en <= en_next & ~(m_amp_dis & ~clr);
            if (brd_wr && w_data[20]) m_pwr <= w_data[19];
            for (int i = 0; i < NUM_AXES; i++) begin
                if (w_valid && w_addr == 16'(((i + 1) << 4) | 1)) begin
                    m_cmd[i*16 +: 16] <= w_data[15:0];
                end
                if (clr[i]) begin
                    m_cnt[i]     <= 0;
                    m_amp_dis[i] <= 1'b0;
                end else if (cur_ready) begin
                    if (sample_mag(cur_fb[i*16 +: 16]) >
                        2*sample_mag(m_cmd[i*16 +: 16]) + int'(MARGIN)) begin
                        m_cnt[i] <= (m_cnt[i] + 1 >= LIMIT) ? LIMIT : m_cnt[i] + 1;
                        if (m_cnt[i] + 1 >= LIMIT) m_amp_dis[i] <= 1'b1;
                    end else begin
                        m_cnt[i] <= 0;
                    end
                end
            end
            if (cur_ready) m_fb <= cur_fb;
            m_rdata <= expected_read(reg_raddr);
        end
    end

    // --------------------
    // checks
    task automatic report_mismatch(string name, logic [63:0] got, logic [63:0] exp);
        err_count++;
        $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
    endtask

    a_cmd: assert property (@(posedge sysclk) disable iff (!rst_n) cur_cmd == m_cmd)
        n_checks++;
        else report_mismatch("cur_cmd", $sampled(cur_cmd), $sampled(m_cmd));
    a_amp_en: assert property (@(posedge sysclk) disable iff (!rst_n) amp_enable == m_amp_en)
        n_checks++;
        else report_mismatch("amp_enable", 64'($sampled(amp_enable)), 64'($sampled(m_amp_en)));
    a_amp_dis: assert property (@(posedge sysclk) disable iff (!rst_n)
        amp_disable == m_amp_dis)
        n_checks++;
        else report_mismatch("amp_disable", 64'($sampled(amp_disable)),
                             64'($sampled(m_amp_dis)));
    a_pwr: assert property (@(posedge sysclk) disable iff (!rst_n) pwr_enable == m_pwr)
        n_checks++;
        else report_mismatch("pwr_enable", 64'($sampled(pwr_enable)), 64'($sampled(m_pwr)));
    a_rdata: assert property (@(posedge sysclk) disable iff (!rst_n) reg_rdata == m_rdata)
        n_checks++;
        else report_mismatch("reg_rdata", 64'($sampled(reg_rdata)), 64'($sampled(m_rdata)));

    // trip and recovery on axis 1 must actually happen
    always @(posedge sysclk) begin
        if (rst_n && amp_disable[0]) saw_trip <= 1'b1;
        if (saw_trip && amp_enable[0] && !amp_disable[0]) saw_restore <= 1'b1;
    end

    always @(posedge sysclk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, stimulus did not finish", cycle_cnt);
            $display("Test failed");
            $finish;
        end
    end

    // --------------------
    // bus and adc stimulus, all on the falling edge
    task automatic bus_write(addr_t a, data_t d);
        @(negedge sysclk);
        reg_wen   = 1'b1;
        reg_waddr = a;
        reg_wdata = d;
        @(negedge sysclk);
        reg_wen = 1'b0;
        repeat (2) @(negedge sysclk);   // decode edge, then register edge
    endtask

    task automatic bus_read(addr_t a);
        @(negedge sysclk);
        reg_raddr = a;
        @(negedge sysclk);
    endtask

    task automatic adc_strobe(samples_t s);
        @(negedge sysclk);
        cur_fb    = s;
        cur_ready = 1'b1;
        @(negedge sysclk);
        cur_ready = 1'b0;
    endtask

    initial begin
        void'($urandom(24464));
        rst_n     = 1'b0;
        reg_wen   = 1'b0;
        reg_waddr = '0;
        reg_wdata = '0;
        reg_raddr = '0;
        cur_fb    = {NUM_AXES{SAMPLE_MID}};
        cur_ready = 1'b0;
        board_id  = 4'ha;
        repeat (RST_CYCLES) @(negedge sysclk);
        rst_n = 1'b1;

        // reset values, commands at midscale
        for (int i = 1; i <= NUM_AXES; i++) bus_read(16'((i << 4) | 1));
        // random commands, written then read back
        for (int i = 0; i < NUM_AXES; i++) begin
            cmd_val[i] = 16'($urandom());
            bus_write(16'(((i + 1) << 4) | 1), {16'h0000, cmd_val[i]});
            bus_read(16'(((i + 1) << 4) | 1));
        end
        // feedback latch, then other blocks
        fb_vec = 64'({$urandom(), $urandom()});
        adc_strobe(fb_vec);
        for (int i = 1; i <= NUM_AXES; i++) bus_read(16'(i << 4));
        bus_write(16'h1011, 32'h0000_1234);    // block 1, must be ignored
        bus_read(16'h1011);
        bus_read(16'h2000);
        // board control, qualified then unqualified
        bus_write(16'h0000, 32'h0038_000f);    // pwr + amps
        bus_read(16'h0000);
        bus_write(16'h0000, 32'h0000_0000);    // no qualifier, no change
        bus_read(16'h0000);
        bus_write(16'h0000, 32'h0000_0005);    // amps w/o WEN
        bus_read(16'h0000);

        // over-current on axis 1, others sit at their command
        cmd_val[0] = 16'h8010;
        bus_write(16'h0011, {16'h0000, cmd_val[0]});
        for (int i = 1; i < NUM_AXES; i++) fb_vec[i*16 +: 16] = cmd_val[i];
        fb_vec[15:0] = 16'h0100;
        adc_strobe(fb_vec);
        adc_strobe(fb_vec);
        fb_vec[15:0] = SAMPLE_MID;             // breaks the streak
        adc_strobe(fb_vec);
        fb_vec[15:0] = 16'h0100;
        for (int k = 0; k < LIMIT; k++) adc_strobe(fb_vec);
        fb_vec[15:0] = SAMPLE_MID;
        cur_fb = fb_vec;
        bus_read(16'h0000);
        // re-enable clears the trip
        bus_write(16'h0000, 32'h0020_000f);
        bus_read(16'h0000);
        @(negedge sysclk);   // last read data compared on this cycle

        if (!saw_trip) begin
            err_count++;
            $display("axis 1 never tripped on sustained over-current");
        end
        if (!saw_restore) begin
            err_count++;
            $display("axis 1 was not re-enabled after the amp enable write");
        end
        $display("checks %0d, errors %0d", n_checks, err_count);
        if (err_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- design/qla_ctrl_top.sv
// --------------------
// register-mapped core, no back-pressure on the host bus
// reg_rdata lags reg_raddr by one clock, writes land one edge after the strobe edge
// --------------------
`timescale 1ns/1ps

module qla_ctrl_top import qla_pkg::*; #(
    parameter sample_t SAFETY_MARGIN = 16'h0200,  // added to 2x command
    parameter int      SAFETY_LIMIT  = 4          // consecutive samples to trip
) (
    input  logic       sysclk,
    input  logic       rst_n,

    // host register bus
    input  logic       reg_wen,      // one-cycle write strobe
    input  addr_t      reg_waddr,
    input  data_t      reg_wdata,
    input  addr_t      reg_raddr,    // sampled every clock
    output data_t      reg_rdata,

    // adc side
    input  samples_t   cur_fb,
    input  logic       cur_ready,    // fresh samples strobe

    input  logic [3:0] board_id,

    output samples_t   cur_cmd,
    output axis_mask_t amp_enable,
    output axis_mask_t amp_disable,
    output logic       pwr_enable
);

    // --------------------
    // internal wires
    axis_mask_t dac_wen;         // one-hot per axis
    logic       board_wen;
    samples_t   cur_fb_latched;
    axis_mask_t clear_disable;   // board write re-enabling an axis

    // decode
    reg_decode u_decode (
        .sysclk    (sysclk),
        .rst_n     (rst_n),
        .reg_wen   (reg_wen),
        .reg_waddr (reg_waddr),
        .dac_wen   (dac_wen),
        .board_wen (board_wen)
    );

    // execute
    axis_cmd_regs u_cmd_regs (
        .sysclk         (sysclk),
        .rst_n          (rst_n),
        .dac_wen        (dac_wen),
        .board_wen      (board_wen),
        .reg_wdata      (reg_wdata),
        .cur_fb         (cur_fb),
        .cur_ready      (cur_ready),
        .amp_disable    (amp_disable),
        .cur_cmd        (cur_cmd),
        .cur_fb_latched (cur_fb_latched),
        .amp_enable     (amp_enable),
        .pwr_enable     (pwr_enable),
        .clear_disable  (clear_disable)
    );

    safety_monitor #(
        .SAFETY_MARGIN (SAFETY_MARGIN),
        .SAFETY_LIMIT  (SAFETY_LIMIT)
    ) u_safety (
        .sysclk        (sysclk),
        .rst_n         (rst_n),
        .cur_fb        (cur_fb),         // live samples, same strobe as the latch
        .cur_cmd       (cur_cmd),
        .cur_ready     (cur_ready),
        .clear_disable (clear_disable),
        .amp_disable   (amp_disable)
    );

    // result
    read_mux u_read_mux (
        .sysclk         (sysclk),
        .rst_n          (rst_n),
        .reg_raddr      (reg_raddr),
        .cur_fb_latched (cur_fb_latched),
        .cur_cmd        (cur_cmd),
        .amp_enable     (amp_enable),
        .amp_disable    (amp_disable),
        .pwr_enable     (pwr_enable),
        .board_id       (board_id),
        .reg_rdata      (reg_rdata)
    );

endmodule

//--- design/read_mux.sv
// --------------------
// registered read data, one clock after reg_raddr
// unmapped addresses and non-main blocks read zero
// --------------------
`timescale 1ns/1ps

module read_mux import qla_pkg::*; (
    input  logic       sysclk,
    input  logic       rst_n,
    input  addr_t      reg_raddr,
    input  samples_t   cur_fb_latched,
    input  samples_t   cur_cmd,
    input  axis_mask_t amp_enable,
    input  axis_mask_t amp_disable,
    input  logic       pwr_enable,
    input  logic [3:0] board_id,
    output data_t      reg_rdata
);

    logic [3:0] rchan;
    logic [3:0] roff;
    data_t      status_word;
    data_t      rd_next;

    assign rchan = addr_chan(reg_raddr);
    assign roff  = addr_off(reg_raddr);

    // board status, same layout as the control write
    always_comb begin
        status_word                              = '0;
        status_word[AMP_EN_LSB +: NUM_AXES]      = amp_enable;
        status_word[AMP_DIS_LSB +: NUM_AXES]     = amp_disable;
        status_word[PWR_EN_BIT]                  = pwr_enable;
        status_word[BOARD_ID_LSB +: 4]           = board_id;
    end

    // --------------------
    // select
    always_comb begin
        rd_next = '0;
        if (addr_blk(reg_raddr) == ADDR_MAIN) begin
            if (rchan == CHAN_BOARD) begin
                if (roff == OFF_BOARD_CTRL) begin
                    rd_next = status_word;
                end
            end else begin
                for (int i = 0; i < NUM_AXES; i++) begin
                    if (rchan == 4'(i + 1)) begin
                        // upper half stays zero, no pot feedback here
                        if (roff == OFF_ADC_DATA) begin
                            rd_next = {16'h0000, get_sample(cur_fb_latched, i)};
                        end else if (roff == OFF_DAC_CTRL) begin
                            rd_next = {16'h0000, get_sample(cur_cmd, i)};
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            reg_rdata <= '0;
        end else begin
            reg_rdata <= rd_next;
        end
    end

endmodule

//--- design/safety_monitor.sv
// --------------------
// per-axis trip when |fb| > 2*|cmd| + SAFETY_MARGIN for SAFETY_LIMIT strobes in a row
// disable is sticky until a clear, SAFETY_LIMIT must be at least 1
// --------------------
`timescale 1ns/1ps

module safety_monitor import qla_pkg::*; #(
    parameter sample_t SAFETY_MARGIN = 16'h0200,
    parameter int      SAFETY_LIMIT  = 4
) (
    input  logic       sysclk,
    input  logic       rst_n,
    input  samples_t   cur_fb,
    input  samples_t   cur_cmd,
    input  logic       cur_ready,
    input  axis_mask_t clear_disable,
    output axis_mask_t amp_disable
);

    localparam int               CNT_W   = $clog2(SAFETY_LIMIT + 1);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(SAFETY_LIMIT);

    logic [CNT_W-1:0] trip_cnt [NUM_AXES];   // consecutive over-current samples
    sample_t          fb_mag   [NUM_AXES];
    sample_t          cmd_mag  [NUM_AXES];
    logic [17:0]      thresh   [NUM_AXES];   // 2*cmd + margin, no overflow
    axis_mask_t       over_cur;

    // distance from midscale
    function automatic sample_t magnitude(sample_t s);
        if (s >= SAMPLE_MID) begin
            return s - SAMPLE_MID;
        end
        return SAMPLE_MID - s;
    endfunction

    // --------------------
    // compare
    always_comb begin
        for (int i = 0; i < NUM_AXES; i++) begin
            fb_mag[i]   = magnitude(get_sample(cur_fb, i));
            cmd_mag[i]  = magnitude(get_sample(cur_cmd, i));
            thresh[i]   = {1'b0, cmd_mag[i], 1'b0} + {2'b00, SAFETY_MARGIN};
            over_cur[i] = {2'b00, fb_mag[i]} > thresh[i];
        end
    end

    // --------------------
    // trip counters
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_AXES; i++) begin
                trip_cnt[i] <= '0;
            end
            amp_disable <= '0;
        end else begin
            for (int i = 0; i < NUM_AXES; i++) begin
                if (clear_disable[i]) begin
                    trip_cnt[i]    <= '0;        // clear wins over a trip
                    amp_disable[i] <= 1'b0;
                end else if (cur_ready) begin
                    if (over_cur[i]) begin
                        if (trip_cnt[i] != CNT_MAX) begin
                            trip_cnt[i] <= trip_cnt[i] + 1'b1;   // saturate
                        end
                        if (trip_cnt[i] >= CNT_MAX - 1'b1) begin
                            amp_disable[i] <= 1'b1;              // limit reached
                        end
                    end else begin
                        trip_cnt[i] <= '0;   // streak broken
                    end
                end
            end
        end
    end

    // a trip needs an adc strobe on the edge it happens
    a_trip_on_ready: assert property (
        @(posedge sysclk) disable iff (!rst_n)
        ((amp_disable & ~$past(amp_disable)) != '0) |-> $past(cur_ready)
    ) else $error("safety_monitor: amp_disable rose without cur_ready");

endmodule

//--- design/axis_cmd_regs.sv
// --------------------
// command, feedback and board control state
// amp enable drops one cycle after its safety disable rises
// --------------------
`timescale 1ns/1ps

module axis_cmd_regs import qla_pkg::*; (
    input  logic       sysclk,
    input  logic       rst_n,
    input  axis_mask_t dac_wen,
    input  logic       board_wen,
    input  data_t      reg_wdata,
    input  samples_t   cur_fb,
    input  logic       cur_ready,
    input  axis_mask_t amp_disable,
    output samples_t   cur_cmd,
    output samples_t   cur_fb_latched,
    output axis_mask_t amp_enable,
    output logic       pwr_enable,
    output axis_mask_t clear_disable
);

    data_t      wdata_q;        // bus data, delayed to line up with decode
    logic       wr_pwr;         // qualified power enable write
    logic       wr_amp;         // qualified amp enable write
    axis_mask_t amp_wr_bits;
    axis_mask_t amp_next;

    always_ff @(posedge sysclk) begin
        wdata_q <= reg_wdata;
    end

    assign wr_pwr      = board_wen && wdata_q[WEN_PWR_BIT];
    assign wr_amp      = board_wen && wdata_q[WEN_AMP_BIT];
    assign amp_wr_bits = wdata_q[AMP_EN_LSB +: NUM_AXES];

    // re-enable by amp bit, or by power-on for every axis
    always_comb begin
        clear_disable = '0;
        if (wr_amp) begin
            clear_disable = amp_wr_bits;
        end
        if (wr_pwr && wdata_q[PWR_EN_BIT]) begin
            clear_disable = '1;
        end
    end

    // --------------------
    // amp and power enables
    always_comb begin
        amp_next = amp_enable;
        if (wr_amp) begin
            amp_next = amp_wr_bits;
        end
        amp_next = amp_next & ~(amp_disable & ~clear_disable);   // clear beats trip
    end

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            amp_enable <= '0;
            pwr_enable <= 1'b0;
        end else begin
            amp_enable <= amp_next;
            if (wr_pwr) begin
                pwr_enable <= wdata_q[PWR_EN_BIT];
            end
        end
    end

    // --------------------
    // current commands, midscale = no current
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            cur_cmd <= {NUM_AXES{SAMPLE_MID}};
        end else begin
            for (int i = 0; i < NUM_AXES; i++) begin
                if (dac_wen[i]) begin
                    cur_cmd[i*SAMPLE_W +: SAMPLE_W] <= wdata_q[SAMPLE_W-1:0];
                end
            end
        end
    end

    // feedback snapshot on every adc strobe
    always_ff @(posedge sysclk) begin
        if (cur_ready) begin
            cur_fb_latched <= cur_fb;
        end
    end

    // enable may overlap a disable for one cycle at most
    a_amp_drop: assert property (
        @(posedge sysclk) disable iff (!rst_n)
        (amp_enable & amp_disable & $past(amp_enable & amp_disable)) == '0
    ) else $error("axis_cmd_regs: amp_enable held while disabled %b", amp_enable);

endmodule

//--- design/reg_decode.sv
// --------------------
// registered write decode, main block only
// enables are one cycle behind reg_wen
// --------------------
`timescale 1ns/1ps

module reg_decode import qla_pkg::*; (
    input  logic       sysclk,
    input  logic       rst_n,
    input  logic       reg_wen,
    input  addr_t      reg_waddr,
    output axis_mask_t dac_wen,     // one-hot, axis 1 in bit 0
    output logic       board_wen
);

    logic       main_hit;   // write aimed at block 0
    logic [3:0] wchan;
    logic [3:0] woff;

    assign main_hit = reg_wen && (addr_blk(reg_waddr) == ADDR_MAIN);
    assign wchan    = addr_chan(reg_waddr);
    assign woff     = addr_off(reg_waddr);

    // --------------------
    // enable registers
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            dac_wen   <= '0;
            board_wen <= 1'b0;
        end else begin
            dac_wen   <= '0;        // strobes, default low
            board_wen <= 1'b0;
            if (main_hit) begin
                if (wchan == CHAN_BOARD) begin
                    // board control word lives at offset 0 only
                    board_wen <= (woff == OFF_BOARD_CTRL);
                end else begin
                    for (int i = 0; i < NUM_AXES; i++) begin
                        // chan i+1 maps to axis bit i
                        if (wchan == 4'(i + 1) && woff == OFF_DAC_CTRL) begin
                            dac_wen[i] <= 1'b1;
                        end
                    end
                end
            end
            // chans above NUM_AXES and other offsets fall through, ignored
        end
    end

    // --------------------
    // checks
    // at most one write target per cycle
    a_wen_exclusive: assert property (
        @(posedge sysclk) disable iff (!rst_n)
        $onehot0(dac_wen) && !(board_wen && (dac_wen != '0))
    ) else $error("reg_decode: overlapping write enables %b %b", dac_wen, board_wen);

endmodule

//--- design/qla_pkg.sv
// --------------------
// register map and widths for the four-axis controller core
// only the main block (0) is decoded, other blocks read as zero
// --------------------
package qla_pkg;

    // --------------------
    // widths
    localparam int NUM_AXES = 4;
    localparam int SAMPLE_W = 16;            // adc and dac word

    typedef logic [31:0]                  data_t;       // bus data word
    typedef logic [15:0]                  addr_t;       // blk | chan | off
    typedef logic [SAMPLE_W-1:0]          sample_t;     // offset binary
    typedef logic [NUM_AXES-1:0]          axis_mask_t;  // bit 0 = axis 1
    typedef logic [NUM_AXES*SAMPLE_W-1:0] samples_t;    // axis 1 in low bits

    // --------------------
    // address map
    localparam logic [3:0] ADDR_MAIN      = 4'd0;  // main block number
    localparam logic [3:0] CHAN_BOARD     = 4'd0;  // board channel
    localparam logic [3:0] OFF_BOARD_CTRL = 4'd0;  // board ctrl/status in chan 0
    localparam logic [3:0] OFF_ADC_DATA   = 4'd0;  // latched feedback, read only
    localparam logic [3:0] OFF_DAC_CTRL   = 4'd1;  // current command

    localparam sample_t SAMPLE_MID = 16'h8000;     // zero current

    // --------------------
    // board word fields, shared by write and status read
    localparam int AMP_EN_LSB   = 0;    // amp enables
    localparam int AMP_DIS_LSB  = 8;    // safety disables, ro
    localparam int PWR_EN_BIT   = 19;
    localparam int WEN_PWR_BIT  = 20;   // qualifies pwr enable write
    localparam int WEN_AMP_BIT  = 21;   // qualifies amp enable write
    localparam int BOARD_ID_LSB = 24;   // board id, ro

    // address field helpers
    function automatic logic [3:0] addr_blk(addr_t a);
        return a[15:12];
    endfunction

    function automatic logic [3:0] addr_chan(addr_t a);
        return a[7:4];
    endfunction

    function automatic logic [3:0] addr_off(addr_t a);
        return a[3:0];
    endfunction

    // pick one axis out of a flattened sample vector, idx 0 = axis 1
    function automatic sample_t get_sample(samples_t v, int idx);
        return v[idx*SAMPLE_W +: SAMPLE_W];
    endfunction

endpackage
